// ==== rom_walk_top.f ====
+incdir+src
src/sdram_pkg.sv
src/cpu_pkg.sv
src/cen_frac.sv
src/rom_wait.sv
src/rom_word_buf.sv
src/rom_walker.sv
src/rom_walk_top.sv
tb/rom_walk_checker.sv
tb/rom_walk_tb.sv

// ==== Makefile ====
TOP = rom_walk_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rom_walk_top.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// ==== tb/rom_walk_tb.sv ====
`include "rom_walk_defines.svh"

module rom_walk_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import sdram_pkg::*;
    import cpu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        go;
    rom_addr_t   start_addr;
    logic        sdram_req;
    rom_addr_t   sdram_addr;
    logic        sdram_ack;
    rom_data_t   sdram_data;
    logic        busy;
    logic        done;
    csum_t       checksum;
    logic [15:0] fetch_count;

    // sdram contents as seen by the buffer
    rom_data_t mem [0:(1 << `ROM_AW) - 1];

    integer value_errs;
    integer timeout_errs;
    integer seed;
    integer req_count;
    integer lat_fixed;
    logic   lat_random;

    rom_walk_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (go),
        .start_addr  (start_addr),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .sdram_data  (sdram_data),
        .busy        (busy),
        .done        (done),
        .checksum    (checksum),
        .fetch_count (fetch_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // each new request counts once
    always @(posedge sdram_req) begin
        req_count = req_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // sdram model

    // one access answered by an ack pulse after a fixed or random latency
    task automatic answer_sdram();
        integer delay;
        delay = lat_random ? 1 + ($unsigned($random(seed)) % 20) : lat_fixed;
        repeat (delay - 1) @(posedge clk);
        sdram_data <= mem[sdram_addr];
        sdram_ack  <= 1'b1;
        @(posedge clk);
        sdram_ack  <= 1'b0;
    endtask

    initial begin
        sdram_ack  = 1'b0;
        sdram_data = '0;
        forever begin
            @(posedge clk);
            if (sdram_req) begin
                answer_sdram();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    task automatic fill_memory();
        // background words mix in every address bit
        for (int i = 0; i < (1 << `ROM_AW); i++) begin
            mem[i] = rom_data_t'(i) ^ 16'h5A5A;
        end
    endtask

    // reference walk over the same array
    task automatic walk_expected(input rom_addr_t start, output csum_t sum,
                                 output logic [15:0] cnt);
        rom_addr_t pc;
        rom_data_t w;
        pc  = start;
        sum = '0;
        cnt = '0;
        do begin
            w   = mem[pc];
            sum = sum + w;
            cnt = cnt + 16'd1;
            if (w[15:12] == `OP_JUMP) begin
                pc = w[`ROM_AW-1:0];
            end else if (w[15:12] != `OP_HALT) begin
                pc = pc + rom_addr_t'(1);
            end
        end while (w[15:12] != `OP_HALT && cnt < 16'd1000);
    endtask

    task automatic pulse_go(input rom_addr_t a);
        @(posedge clk);
        start_addr <= a;
        go         <= 1'b1;
        @(posedge clk);
        go         <= 1'b0;
        // old done is cleared by now
        @(posedge clk);
    endtask

    task automatic wait_done(input integer limit);
        integer n;
        n = 0;
        while (!done && n < limit) begin
            @(posedge clk);
            n = n + 1;
        end
        if (!done) begin
            timeout_errs = timeout_errs + 1;
            $display("Timeout at %0t ns, done did not rise within %0d cycles", $time, limit);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_csum(input csum_t got, input csum_t exp);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail at %0t ns: checksum got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail at %0t ns: fetch_count got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_req_count(input integer got, input integer exp);
        if (got != exp) begin
            value_errs = value_errs + 1;
            $display("Fail at %0t ns: sdram requests got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_addr(input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail at %0t ns: sdram_addr got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic run_and_check(input rom_addr_t start);
        csum_t       exp_sum;
        logic [15:0] exp_cnt;
        walk_expected(start, exp_sum, exp_cnt);
        pulse_go(start);
        check_flag("busy", busy, 1'b1);
        wait_done(2000);
        check_flag("busy", busy, 1'b0);
        check_csum(checksum, exp_sum);
        check_count(fetch_count, exp_cnt);
    endtask

    // nothing moves without go
    task automatic quiet_after_reset();
        repeat (50) begin
            @(posedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_flag("sdram_req", sdram_req, 1'b0);
        end
    endtask

    // seven plain words then halt
    task automatic linear_program();
        for (int i = 0; i < 7; i++) begin
            mem[12'h100 + i] = 16'h0123 + rom_data_t'(i * 16'h1111);
        end
        mem[12'h107] = 16'hE042;
        run_and_check(12'h100);
        check_count(fetch_count, 16'd8);
        // the halt word was the last one fetched from sdram
        check_addr(sdram_addr, 12'h107);
    endtask

    // 200 -> 201 jumps ahead to 208, 209 jumps back to 202, 203 halts
    task automatic jump_program();
        mem[12'h200] = 16'h1111;
        mem[12'h201] = 16'hF208;
        mem[12'h202] = 16'h3333;
        mem[12'h203] = 16'hE000;
        mem[12'h208] = 16'h2222;
        mem[12'h209] = 16'hF202;
        run_and_check(12'h200);
    endtask

    // second run hits the buffer entry left by the first
    task automatic buffer_rerun();
        mem[12'h300] = 16'hE0A5;
        req_count = 0;
        run_and_check(12'h300);
        run_and_check(12'h300);
        check_req_count(req_count, 1);
        check_addr(sdram_addr, 12'h300);
    endtask

    task automatic random_latency_run();
        lat_random = 1'b1;
        run_and_check(12'h200);
        lat_random = 1'b0;
    endtask

    initial begin
        value_errs   = 0;
        timeout_errs = 0;
        seed         = 28;
        req_count    = 0;
        lat_fixed    = 3;
        lat_random   = 1'b0;
        rst_n        = 1'b0;
        go           = 1'b0;
        start_addr   = '0;
        fill_memory();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        quiet_after_reset();
        linear_program();
        jump_program();
        buffer_rerun();
        random_latency_run();
        $display("value errors: %0d, timeouts: %0d", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb/rom_walk_checker.sv ====
// protocol and stall checks on the walk subsystem
module rom_walk_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 gate,
    input logic                 cen_out,
    input logic                 rom_cs,
    input logic                 rom_ok,
    input logic                 sdram_req,
    input sdram_pkg::rom_addr_t sdram_addr,
    input logic                 sdram_ack,
    input logic                 busy,
    input logic                 done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic last_cs;
    // rom access opened and rom_ok not yet seen
    logic pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_cs <= 1'b0;
            pend    <= 1'b0;
        end else begin
            last_cs <= rom_cs;
            if (rom_ok) begin
                pend <= 1'b0;
            end else if (rom_cs && !last_cs) begin
                pend <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // assertions

    // masked pulse never leaks through the output register
    assert property (@(posedge clk) disable iff (!rst_n) !gate |=> !cen_out)
        else $error("cen_out high in the cycle after gate was low");

    // request held with a steady address until the ack
    assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or sdram_addr moved before sdram_ack");

    // cpu stays stalled while the rom word is pending
    assert property (@(posedge clk) disable iff (!rst_n) pend |-> !cen_out)
        else $error("cen_out pulsed before rom_ok was seen");

    assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done both high");

endmodule

bind rom_walk_top rom_walk_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .gate       (gate),
    .cen_out    (cen_out),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .sdram_req  (sdram_req),
    .sdram_addr (sdram_addr),
    .sdram_ack  (sdram_ack),
    .busy       (busy),
    .done       (done)
);

// ==== src/rom_walk_top.sv ====
// cpu clock enable subsystem
// generator, rom wait gate, word buffer and walker
module rom_walk_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // control
    input  logic                 go,
    input  sdram_pkg::rom_addr_t start_addr,
    // sdram port
    output logic                 sdram_req,
    output sdram_pkg::rom_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  sdram_pkg::rom_data_t sdram_data,
    // status
    output logic                 busy,
    output logic                 done,
    output cpu_pkg::csum_t       checksum,
    output logic [15:0]          fetch_count
);

    import sdram_pkg::*;

    logic      cen;
    logic      cen_out;
    // kept internal, probed by the checker
    logic      gate;
    logic      rom_cs;
    logic      rom_ok;
    rom_addr_t rom_addr;
    rom_data_t rom_data;

    //////////////////////////////////////////////////////////////////////
    // clock enable path

    cen_frac u_cen (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen)
    );

    rom_wait u_wait (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_in  (cen),
        .rom_cs  (rom_cs),
        .rom_ok  (rom_ok),
        .cen_out (cen_out),
        .gate    (gate)
    );

    //////////////////////////////////////////////////////////////////////
    // rom buffer and cpu

    rom_word_buf u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .sdram_data (sdram_data)
    );

    rom_walker u_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen_out),
        .go          (go),
        .start_addr  (start_addr),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .busy        (busy),
        .done        (done),
        .checksum    (checksum),
        .fetch_count (fetch_count)
    );

endmodule

// ==== src/rom_walker.sv ====
`include "rom_walk_defines.svh"

// tiny program walker
// fetches one word per two cen pulses and follows jumps
module rom_walker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    // control
    input  logic                 go,
    input  sdram_pkg::rom_addr_t start_addr,
    // rom bus
    output logic                 rom_cs,
    output sdram_pkg::rom_addr_t rom_addr,
    input  sdram_pkg::rom_data_t rom_data,
    // status
    output logic                 busy,
    output logic                 done,
    output cpu_pkg::csum_t       checksum,
    output logic [15:0]          fetch_count
);

    import sdram_pkg::*;
    import cpu_pkg::*;

    logic      phase_b;
    rom_addr_t pc;
    insn_t     insn;

    // address is only moved while rom_cs is low
    assign rom_addr = pc;

    // fetched word, two views
    assign insn.raw = rom_data;

    //////////////////////////////////////////////////////////////////////
    // fetch and step

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            phase_b     <= 1'b0;
            rom_cs      <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            checksum    <= '0;
            fetch_count <= '0;
        end else if (go) begin
            // fresh run from start_addr
            pc          <= start_addr;
            phase_b     <= 1'b0;
            rom_cs      <= 1'b0;
            busy        <= 1'b1;
            done        <= 1'b0;
            checksum    <= '0;
            fetch_count <= '0;
        end else if (busy && cen) begin
            if (!phase_b) begin
                // phase a, open the access
                rom_cs  <= 1'b1;
                phase_b <= 1'b1;
            end else begin
                // phase b, word is valid now
                rom_cs      <= 1'b0;
                phase_b     <= 1'b0;
                checksum    <= checksum + insn.raw;
                fetch_count <= fetch_count + 16'd1;
                case (insn.f.op)
                    `OP_JUMP: pc <= insn.f.arg;
                    `OP_HALT: begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                    default:  pc <= pc + 1'b1;
                endcase
            end
        end
    end

endmodule

// ==== src/rom_word_buf.sv ====
// one entry rom word buffer in front of the sdram port
// hits answer in the same cycle, misses go out to sdram
module rom_word_buf (
    input  logic                 clk,
    input  logic                 rst_n,
    // cpu side
    input  logic                 rom_cs,
    input  sdram_pkg::rom_addr_t rom_addr,
    output logic                 rom_ok,
    output sdram_pkg::rom_data_t rom_data,
    // sdram side
    output logic                 sdram_req,
    output sdram_pkg::rom_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  sdram_pkg::rom_data_t sdram_data
);

    import sdram_pkg::*;

    // request fsm encoding
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_REQ  = 1'b1;

    logic      state;
    logic      valid;
    rom_addr_t tag;
    rom_data_t data;
    logic      hit;
    logic      miss;

    //////////////////////////////////////////////////////////////////////
    // lookup

    // entry matches the current address
    assign hit  = valid && (tag == rom_addr);
    assign miss = rom_cs && !hit;

    // answer straight from the entry
    assign rom_ok   = rom_cs && hit;
    assign rom_data = data;

    // request is held for the whole ST_REQ state
    assign sdram_req = (state == ST_REQ);

    //////////////////////////////////////////////////////////////////////
    // request fsm and entry valid

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // miss seen, go out to sdram next cycle
                    if (miss) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // entry filled on the ack, req drops after it
                    if (sdram_ack) begin
                        state <= ST_IDLE;
                        valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload, no reset

    always_ff @(posedge clk) begin
        // address latched as the request starts, stable until ack
        if (state == ST_IDLE && miss) begin
            sdram_addr <= rom_addr;
        end
        // fill tag and word together
        if (state == ST_REQ && sdram_ack) begin
            tag  <= sdram_addr;
            data <= sdram_data;
        end
    end

endmodule

// ==== src/rom_wait.sv ====
// clock enable gate for rom accesses
// stalls the cpu from a rising rom_cs until rom_ok is seen
module rom_wait (
    input  logic clk,
    input  logic rst_n,
    input  logic cen_in,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic cen_out,
    output logic gate
);

    //////////////////////////////////////////////////////////////////////
    // rom_cs edge and lock

    logic last_rom_cs;
    logic rom_cs_rise;
    logic locked;
    logic bus_ok;

    // new access starts this cycle
    assign rom_cs_rise = rom_cs && !last_rom_cs;

    // data ready, or no access pending
    assign bus_ok = rom_ok || !rom_cs;

    // block pulses on the edge itself and while locked
    assign gate = !(rom_cs_rise || locked);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // starts high so leaving reset is not an edge
            last_rom_cs <= 1'b1;
            locked      <= 1'b0;
        end else begin
            last_rom_cs <= rom_cs;
            if (rom_cs_rise) begin
                locked <= 1'b1;
            end else if (bus_ok) begin
                locked <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // gated clock enable, one cycle late

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_out <= 1'b0;
        end else begin
            cen_out <= cen_in & gate;
        end
    end

endmodule

// ==== src/cen_frac.sv ====
`include "rom_walk_defines.svh"

// fractional clock enable
// cen is high in CEN_NUM out of every CEN_DEN cycles
module cen_frac (
    input  logic clk,
    input  logic rst_n,
    output logic cen
);

    // room for acc + num without overflow
    localparam int AW = $clog2(`CEN_DEN + `CEN_NUM) + 1;
    localparam logic [AW-1:0] NUM = AW'(`CEN_NUM);
    localparam logic [AW-1:0] DEN = AW'(`CEN_DEN);

    logic [AW-1:0] acc;
    logic [AW-1:0] sum;

    // next accumulator value before wrap
    assign sum = acc + NUM;

    //////////////////////////////////////////////////////////////////////
    // accumulator

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else begin
            if (sum >= DEN) begin
                // wrap and emit one pulse
                acc <= sum - DEN;
                cen <= 1'b1;
            end else begin
                acc <= sum;
                cen <= 1'b0;
            end
        end
    end

endmodule

// ==== src/cpu_pkg.sv ====
`include "rom_walk_defines.svh"

// walker side view of rom words
package cpu_pkg;

    // decoded instruction fields
    // op sits in the top nibble, arg is a full rom word address
    typedef struct packed {
        logic [3:0]         op;
        logic [`ROM_AW-1:0] arg;
    } insn_fields_t;

    // one fetched word, read raw for the checksum
    // and as fields for the step logic
    typedef union packed {
        sdram_pkg::rom_data_t raw;
        insn_fields_t         f;
    } insn_t;

    // running sum of every fetched word, wraps at 16 bits
    typedef logic [15:0] csum_t;

endpackage

// ==== src/sdram_pkg.sv ====
`include "rom_walk_defines.svh"

// types seen on both sides of the rom word buffer
package sdram_pkg;

    // word address into program rom
    typedef logic [`ROM_AW-1:0] rom_addr_t;

    // one rom word as stored in sdram
    typedef logic [15:0] rom_data_t;

endpackage

// ==== src/rom_walk_defines.svh ====
`ifndef ROM_WALK_DEFINES_SVH
`define ROM_WALK_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// rom geometry

// word address width of program rom
`define ROM_AW 12

//////////////////////////////////////////////////////////////////////
// clock enable ratio

// cpu runs at CEN_NUM / CEN_DEN of clk
`define CEN_NUM 1
`define CEN_DEN 3

//////////////////////////////////////////////////////////////////////
// walker opcodes

// jump to arg
`define OP_JUMP 4'hF
// stop walking
`define OP_HALT 4'hE

`endif
